// ==== rtl/dcache_macros.svh ====
// widths assume 4-byte lines and 16 lines, byte ordering logic depends on both
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// byte address
`define DC_ADDR_W 17

// one data word, also one cache line
`define DC_DATA_W 32

// direct-mapped geometry
`define DC_LINES 16
`define DC_INDEX_W 4
`define DC_OFFSET_W 2

// whatever is left above index and offset
`define DC_TAG_W (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

`endif

// ==== rtl/dcache_pkg.sv ====
// types for the cache, enum encodings are shared with the memory side and the client
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0] addr_t;
    typedef logic [`DC_DATA_W-1:0] word_t;
    typedef logic [`DC_TAG_W-1:0] tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [`DC_OFFSET_W-1:0] offset_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_e;

    typedef enum logic [1:0] {
        req_nop = 2'd0,
        req_load = 2'd1,
        req_store = 2'd2
    } req_e;

    typedef enum logic [1:0] {
        mem_nop = 2'd0,
        mem_read = 2'd1,
        mem_write = 2'd2
    } mem_cmd_e;

    typedef enum logic [2:0] {
        st_idle = 3'd0,
        st_wait_ready = 3'd1,
        st_fill_first = 3'd2,
        st_fill_second = 3'd3,
        st_write = 3'd4,
        st_respond = 3'd5
    } seq_state_e;

endpackage

// ==== rtl/line_store.sv ====
// lines hold bytes in memory order (offset 0 in bits 31:24); wdata is in normal order
`include "dcache_macros.svh"

module line_store
    import dcache_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  addr_t        addr,
    input  access_size_e size,
    input  logic         store_en,
    input  word_t        wdata,
    input  logic         fill_en,
    input  addr_t        fill_addr,
    input  word_t        fill_data,
    output logic         load_hit,
    output word_t        line_lo,
    output word_t        line_hi
);

    logic [`DC_LINES-1:0] valid_q;
    tag_t tag_q [`DC_LINES];
    word_t data_q [`DC_LINES];

    addr_t addr_hi;
    index_t idx_lo;
    index_t idx_hi;
    index_t fill_idx;
    tag_t tag_lo;
    tag_t tag_hi;
    offset_t offset;
    logic [1:0] span;
    logic [2:0] last_pos;
    logic hit_lo;
    logic hit_hi;
    word_t merged_lo;
    word_t merged_hi;
    logic [2:0] pos;
    logic [1:0] slot;

    // second line is whatever holds addr + 4, with its own tag
    assign addr_hi = addr + addr_t'(4);
    assign idx_lo = addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign idx_hi = addr_hi[`DC_OFFSET_W +: `DC_INDEX_W];
    assign tag_lo = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign tag_hi = addr_hi[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign offset = addr[`DC_OFFSET_W-1:0];
    assign fill_idx = fill_addr[`DC_OFFSET_W +: `DC_INDEX_W];

    always_comb begin
        case (size)
            size_byte: span = 2'd0;
            size_half: span = 2'd1;
            default:   span = 2'd3;
        endcase
    end

    assign last_pos = {1'b0, offset} + {1'b0, span};
    assign hit_lo = valid_q[idx_lo] && (tag_q[idx_lo] == tag_lo);
    assign hit_hi = valid_q[idx_hi] && (tag_q[idx_hi] == tag_hi);

    // bit 2 of the last byte position means the access runs into the next line
    assign load_hit = hit_lo && (!last_pos[2] || hit_hi);
    assign line_lo = data_q[idx_lo];
    assign line_hi = data_q[idx_hi];

    // byte k of wdata lands at addr + k
    always_comb begin
        merged_lo = data_q[idx_lo];
        merged_hi = data_q[idx_hi];
        pos = 3'd0;
        slot = 2'd0;
        for (int k = 0; k < 4; k++) begin
            if (2'(k) <= span) begin
                pos = {1'b0, offset} + 3'(k);
                slot = ~pos[1:0];
                if (!pos[2]) begin
                    merged_lo[8*slot +: 8] = wdata[8*k +: 8];
                end else begin
                    merged_hi[8*slot +: 8] = wdata[8*k +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[fill_idx] <= fill_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
            data_q[fill_idx] <= fill_data;
        end else if (store_en) begin
            // a missing line keeps its old bytes, memory gets them anyway
            if (hit_lo) begin
                data_q[idx_lo] <= merged_lo;
            end
            if (hit_hi) begin
                data_q[idx_hi] <= merged_hi;
            end
        end
    end

    a_no_store_during_fill: assert property (
        @(posedge clk) disable iff (rst) !(store_en && fill_en)
    );

endmodule

// ==== rtl/load_align.sv ====
// purely combinational; both lines are taken in memory order, second line may be unused
`include "dcache_macros.svh"

module load_align
    import dcache_pkg::*;
(
    input  offset_t      offset,
    input  access_size_e size,
    input  word_t        line_lo,
    input  word_t        line_hi,
    output word_t        data
);

    logic [2*`DC_DATA_W-1:0] joined;
    logic [2*`DC_DATA_W-1:0] shifted;
    word_t window;
    word_t normal;

    // eight consecutive bytes, lowest address on top
    assign joined = {line_lo, line_hi};

    // drop the bytes before offset so the access starts at the top
    assign shifted = joined << (8 * offset);
    assign window = shifted[2*`DC_DATA_W-1 -: `DC_DATA_W];

    // lowest address becomes the least significant byte
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            normal[8*b +: 8] = window[8*(3-b) +: 8];
        end
    end

    always_comb begin
        case (size)
            size_byte: data = {{24{normal[7]}}, normal[7:0]};
            size_half: data = {{16{normal[15]}}, normal[15:0]};
            default:   data = normal;
        endcase
    end

endmodule

// ==== rtl/miss_sequencer.sv ====
// one request in flight; mem_cmd and its operands are registered and held until mem_done
`include "dcache_macros.svh"

module miss_sequencer
    import dcache_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  req_e         req,
    input  addr_t        addr,
    input  access_size_e size,
    input  word_t        wdata,
    input  logic         load_hit,
    input  word_t        aligned_data,
    input  logic         mem_ready,
    input  logic         mem_done,
    input  word_t        mem_rdata,
    output addr_t        lookup_addr,
    output access_size_e lookup_size,
    output logic         store_en,
    output logic         fill_en,
    output addr_t        fill_addr,
    output logic         busy,
    output logic         done,
    output word_t        rdata,
    output mem_cmd_e     mem_cmd,
    output addr_t        mem_addr,
    output word_t        mem_wdata,
    output access_size_e mem_wsize
);

    seq_state_e state_q;
    mem_cmd_e mem_cmd_q;
    logic is_store_q;
    addr_t addr_q;
    access_size_e size_q;
    addr_t mem_addr_q;
    word_t mem_wdata_q;
    word_t wdata_rev;
    word_t wdata_mem;
    addr_t next_addr;
    logic idle;

    assign idle = (state_q == st_idle);
    assign next_addr = addr_q + addr_t'(4);

    // store data goes out in memory order, left-justified
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            wdata_rev[8*b +: 8] = wdata[8*(3-b) +: 8];
        end
        case (size)
            size_byte: wdata_mem = {wdata_rev[31:24], 24'b0};
            size_half: wdata_mem = {wdata_rev[31:16], 16'b0};
            default:   wdata_mem = wdata_rev;
        endcase
    end

    // respond looks at the captured address, after the refills
    assign lookup_addr = idle ? addr : addr_q;
    assign lookup_size = idle ? size : size_q;
    assign store_en = idle && (req == req_store);
    assign fill_en = mem_done && (mem_cmd_q == mem_read)
                     && (state_q == st_fill_first || state_q == st_fill_second);
    assign fill_addr = mem_addr_q;

    assign busy = !idle;
    assign done = (state_q == st_respond);
    assign rdata = done ? aligned_data : '0;

    assign mem_cmd = mem_cmd_q;
    assign mem_addr = mem_addr_q;
    assign mem_wdata = mem_wdata_q;
    assign mem_wsize = size_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
            mem_cmd_q <= mem_nop;
        end else begin
            case (state_q)
                st_idle: begin
                    if (req == req_load) begin
                        state_q <= load_hit ? st_respond : st_wait_ready;
                    end else if (req == req_store) begin
                        state_q <= st_wait_ready;
                    end
                end
                st_wait_ready: begin
                    if (mem_ready) begin
                        mem_cmd_q <= is_store_q ? mem_write : mem_read;
                        state_q <= is_store_q ? st_write : st_fill_first;
                    end
                end
                st_fill_first: begin
                    if (mem_done) begin
                        mem_cmd_q <= mem_nop;
                        state_q <= st_fill_second;
                    end
                end
                st_fill_second: begin
                    // issue the second read once memory is idle again
                    if (mem_cmd_q == mem_nop && mem_ready) begin
                        mem_cmd_q <= mem_read;
                    end else if (mem_cmd_q == mem_read && mem_done) begin
                        mem_cmd_q <= mem_nop;
                        state_q <= st_respond;
                    end
                end
                st_write: begin
                    if (mem_done) begin
                        mem_cmd_q <= mem_nop;
                        state_q <= st_respond;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (idle && req != req_nop) begin
            is_store_q <= (req == req_store);
            addr_q <= addr;
            size_q <= size;
            mem_wdata_q <= wdata_mem;
        end
        if (state_q == st_wait_ready && mem_ready) begin
            mem_addr_q <= is_store_q ? addr_q
                                     : {addr_q[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
        end else if (state_q == st_fill_second && mem_cmd_q == mem_nop && mem_ready) begin
            mem_addr_q <= {next_addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
        end
    end

    a_mem_operands_stable: assert property (
        @(posedge clk) disable iff (rst)
        (mem_cmd != mem_nop && !mem_done) |=>
            ($stable(mem_cmd) && $stable(mem_addr) && $stable(mem_wdata) && $stable(mem_wsize))
    );

    a_done_single_pulse: assert property (
        @(posedge clk) disable iff (rst) done |=> !done
    );

    // a refill must never load unknown bytes into a valid line
    a_fill_data_known: assert property (
        @(posedge clk) disable iff (rst) fill_en |-> !$isunknown(mem_rdata)
    );

endmodule

// ==== rtl/data_cache.sv ====
// direct-mapped write-through cache, 16 lines of 4 bytes; client data in normal byte order
`include "dcache_macros.svh"

module data_cache
    import dcache_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    // client side
    input  req_e         req,
    input  addr_t        addr,
    input  access_size_e size,
    input  word_t        wdata,
    output logic         hit,
    output word_t        rdata,
    output logic         done,
    output logic         busy,
    // memory side
    output mem_cmd_e     mem_cmd,
    output addr_t        mem_addr,
    output word_t        mem_wdata,
    output access_size_e mem_wsize,
    input  logic         mem_ready,
    input  logic         mem_done,
    input  word_t        mem_rdata
);

    addr_t lookup_addr;
    access_size_e lookup_size;
    logic store_en;
    logic fill_en;
    addr_t fill_addr;
    word_t line_lo;
    word_t line_hi;
    word_t aligned_data;

    line_store i_line_store (
        .clk       (clk),
        .rst       (rst),
        .addr      (lookup_addr),
        .size      (lookup_size),
        .store_en  (store_en),
        .wdata     (wdata),
        .fill_en   (fill_en),
        .fill_addr (fill_addr),
        .fill_data (mem_rdata),
        .load_hit  (hit),
        .line_lo   (line_lo),
        .line_hi   (line_hi)
    );

    load_align i_load_align (
        .offset  (lookup_addr[`DC_OFFSET_W-1:0]),
        .size    (lookup_size),
        .line_lo (line_lo),
        .line_hi (line_hi),
        .data    (aligned_data)
    );

    miss_sequencer i_miss_sequencer (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .addr         (addr),
        .size         (size),
        .wdata        (wdata),
        .load_hit     (hit),
        .aligned_data (aligned_data),
        .mem_ready    (mem_ready),
        .mem_done     (mem_done),
        .mem_rdata    (mem_rdata),
        .lookup_addr  (lookup_addr),
        .lookup_size  (lookup_size),
        .store_en     (store_en),
        .fill_en      (fill_en),
        .fill_addr    (fill_addr),
        .busy         (busy),
        .done         (done),
        .rdata        (rdata),
        .mem_cmd      (mem_cmd),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_wsize    (mem_wsize)
    );

endmodule

// ==== dv/data_cache_tb.sv ====
// random loads and stores from two 32-byte regions; memory model spans 128 bytes, one request at a time
module data_cache_tb
    import dcache_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_OPS = 400;
    localparam int MEM_BYTES = 128;

    logic clk;
    logic rst;
    req_e req;
    addr_t addr;
    access_size_e size;
    word_t wdata;
    logic hit;
    word_t rdata;
    logic done;
    logic busy;
    mem_cmd_e mem_cmd;
    addr_t mem_addr;
    word_t mem_wdata;
    access_size_e mem_wsize;
    logic mem_ready;
    logic mem_done;
    word_t mem_rdata;

    integer seed = 32'h8a0b;
    integer mem_seed = 32'h8a0b;
    logic [7:0] mem_bytes [MEM_BYTES];
    logic [7:0] ref_mem [MEM_BYTES];
    logic model_valid [16];
    int model_tag [16];
    addr_t read_log [$];
    addr_t wr_addr_log [$];
    access_size_e wr_size_log [$];
    word_t wr_data_log [$];

    data_cache i_data_cache (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_OPS * 40 * CLK_PERIOD);
        $display("Checks failed");
        $fatal(1, "watchdog expired, the run did not finish in time");
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    function automatic int byte_count(input access_size_e s);
        case (s)
            size_byte: return 1;
            size_half: return 2;
            default:   return 4;
        endcase
    endfunction

    // tag is everything above the 64-byte index range
    function automatic logic line_present(input int line);
        return model_valid[line % 16] && (model_tag[line % 16] == line / 16);
    endfunction

    function automatic logic predict_hit(input int a, input access_size_e s);
        if (!line_present(a / 4)) begin
            return 1'b0;
        end
        if ((a % 4) + byte_count(s) > 4) begin
            return line_present((a + 4) / 4);
        end
        return 1'b1;
    endfunction

    function automatic logic [31:0] expected_load(input int a, input access_size_e s);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < byte_count(s); k++) begin
            v[8*k +: 8] = ref_mem[a + k];
        end
        if (s == size_byte) begin
            v = {{24{v[7]}}, v[7:0]};
        end else if (s == size_half) begin
            v = {{16{v[15]}}, v[15:0]};
        end
        return v;
    endfunction

    task automatic run_access(input req_e kind, input int a, input access_size_e s,
                              input logic [31:0] d, output logic got_hit);
        logic exp_hit;
        int cycles;
        logic [31:0] exp_wdata;
        exp_hit = predict_hit(a, s);
        req <= kind;
        addr <= addr_t'(a);
        size <= s;
        wdata <= d;
        @(posedge clk);
        check_value("busy before accept", 32'd0, 32'(busy));
        got_hit = hit;
        if (kind == req_load) begin
            check_value("load hit flag", 32'(exp_hit), 32'(hit));
        end
        req <= req_nop;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            check_value("busy while pending", 32'd1, 32'(busy));
        end while (!done);
        if (kind == req_load) begin
            check_value("load data", expected_load(a, s), rdata);
            check_value("load write count", 32'd0, 32'(wr_addr_log.size()));
            if (exp_hit) begin
                check_value("hit latency", 32'd1, 32'(cycles));
                check_value("hit read count", 32'd0, 32'(read_log.size()));
            end else begin
                check_value("miss read count", 32'd2, 32'(read_log.size()));
                check_value("first refill address", 32'(a & ~3), 32'(read_log[0]));
                check_value("second refill address", 32'((a + 4) & ~3), 32'(read_log[1]));
                model_valid[(a / 4) % 16] = 1'b1;
                model_tag[(a / 4) % 16] = a / 64;
                model_valid[((a + 4) / 4) % 16] = 1'b1;
                model_tag[((a + 4) / 4) % 16] = (a + 4) / 64;
            end
        end else begin
            // memory order, left-justified
            exp_wdata = '0;
            for (int k = 0; k < byte_count(s); k++) begin
                exp_wdata[31 - 8*k -: 8] = d[8*k +: 8];
                ref_mem[a + k] = d[8*k +: 8];
            end
            check_value("store read count", 32'd0, 32'(read_log.size()));
            check_value("store write count", 32'd1, 32'(wr_addr_log.size()));
            check_value("store address", 32'(a), 32'(wr_addr_log[0]));
            check_value("store size", 32'(s), 32'(wr_size_log[0]));
            check_value("store data", exp_wdata, wr_data_log[0]);
        end
        read_log.delete();
        wr_addr_log.delete();
        wr_size_log.delete();
        wr_data_log.delete();
    endtask

    initial begin : memory_responder
        int base;
        logic [31:0] rline;
        mem_ready <= 1'b1;
        mem_done <= 1'b0;
        mem_rdata <= '0;
        forever begin
            @(posedge clk);
            if (!rst && mem_cmd != mem_nop) begin
                base = int'(mem_addr);
                mem_ready <= 1'b0;
                rline = '0;
                if (mem_cmd == mem_read) begin
                    read_log.push_back(mem_addr);
                    rline = {mem_bytes[base], mem_bytes[base + 1],
                             mem_bytes[base + 2], mem_bytes[base + 3]};
                end else begin
                    wr_addr_log.push_back(mem_addr);
                    wr_size_log.push_back(mem_wsize);
                    wr_data_log.push_back(mem_wdata);
                    for (int k = 0; k < byte_count(mem_wsize); k++) begin
                        mem_bytes[base + k] = mem_wdata[31 - 8*k -: 8];
                    end
                end
                repeat ($unsigned($random(mem_seed)) % 6) @(posedge clk);
                mem_done <= 1'b1;
                mem_rdata <= rline;
                @(posedge clk);
                mem_done <= 1'b0;
                // memory stays busy for a few more cycles
                repeat ($unsigned($random(mem_seed)) % 4) @(posedge clk);
                mem_ready <= 1'b1;
            end
        end
    end

    initial begin
        req_e kind;
        access_size_e s;
        int a;
        int ops;
        logic got_hit;
        logic [7:0] b;
        rst <= 1'b1;
        req <= req_nop;
        addr <= '0;
        size <= size_byte;
        wdata <= '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            b = 8'($random(seed));
            mem_bytes[i] = b;
            ref_mem[i] = b;
        end
        for (int i = 0; i < 16; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i] = 0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("busy after reset", 32'd0, 32'(busy));
        check_value("done after reset", 32'd0, 32'(done));
        check_value("mem_cmd after reset", 32'(mem_nop), 32'(mem_cmd));
        ops = 0;
        while (ops < NUM_OPS) begin
            kind = (($random(seed) & 3) == 0) ? req_store : req_load;
            s = access_size_e'(2'($unsigned($random(seed)) % 3));
            // bytes 0..31 and 64..95 share indices 0..7
            a = (($random(seed) & 1) << 6) | ($random(seed) & 31);
            run_access(kind, a, s, $random(seed), got_hit);
            ops++;
            // the model now holds both lines, so the reload must report a hit
            if (kind == req_load && !got_hit) begin
                run_access(req_load, a, s, 32'd0, got_hit);
                ops++;
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/line_store.sv
rtl/load_align.sv
rtl/miss_sequencer.sv
rtl/data_cache.sv
dv/data_cache_tb.sv

// ==== Makefile ====
TOP := data_cache_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
